/* rtl/mem_pkg.sv */
`default_nettype none

package mem_pkg;

	typedef logic [31:0] word_t;
	typedef logic [3:0]  reg_num_t;
	typedef logic [15:0] reg_list_t;
	typedef logic [2:0]  bus_size_t;

	localparam bus_size_t SIZE_BYTE = 3'd1;
	localparam bus_size_t SIZE_WORD = 3'd4;

	// address bits 9:2 select the data RAM word.
	localparam int RAM_WORDS  = 256;
	localparam int RAM_ADDR_W = 8;

	localparam logic [3:0] WAIT_CYCLES = 4'd1;

	typedef enum logic [1:0] {
		CLS_OTHER,
		CLS_LDRSTR,
		CLS_LDMSTM,
		CLS_SWP
	} insn_class_t;

	typedef enum logic [2:0] {
		ST_ACCESS,
		ST_SWP_WRITE,
		ST_BASE_WB,
		ST_LIST_SETUP,
		ST_LIST_XFER
	} stage_state_t;

	// the condition field is ignored here because the earlier stage has already resolved it.
	function automatic insn_class_t decode_class(input word_t insn);
		insn_class_t cls;
		cls = CLS_OTHER;
		if (insn[27:23] == 5'b00010 && insn[21:20] == 2'b00 && insn[11:4] == 8'b0000_1001)
			cls = CLS_SWP;
		else if (insn[27:26] == 2'b01 && !(insn[25] && insn[4]))
			cls = CLS_LDRSTR;
		else if (insn[27:25] == 3'b100)
			cls = CLS_LDMSTM;
		return cls;
	endfunction

endpackage

`default_nettype wire

/* rtl/ldm_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module ldm_sequencer (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               list_load,
	input  logic               list_step,
	input  mem_pkg::reg_list_t reg_list,
	input  logic               descending,
	output mem_pkg::reg_num_t  cur_reg,
	output mem_pkg::word_t     list_offset,
	output logic               list_last
);
	import mem_pkg::*;

	reg_list_t pending;
	reg_list_t reversed;
	reg_num_t  low_idx;
	logic      desc_q;

	always_comb begin
		for (int i = 0; i < 16; i++)
			reversed[i] = reg_list[15 - i];
	end

	// priority pick of the lowest pending bit.
	always_comb begin
		low_idx = '0;
		for (int i = 15; i >= 0; i--) begin
			if (pending[i])
				low_idx = reg_num_t'(i);
		end
	end

	// a descending list is walked from the top register down.
	assign cur_reg   = desc_q ? ~low_idx : low_idx;
	assign list_last = (pending != '0) && ((pending & (pending - 1'b1)) == '0);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pending     <= '0;
			desc_q      <= 1'b0;
			list_offset <= '0;
		end else if (list_load) begin
			pending     <= descending ? reversed : reg_list;
			desc_q      <= descending;
			list_offset <= '0;
		end else if (list_step) begin
			pending[low_idx] <= 1'b0;
			list_offset      <= list_offset + 32'd4;
		end
	end

	a_step_nonempty: assert property (@(posedge clk) disable iff (!rst_n)
		list_step |-> pending != '0);

endmodule

`default_nettype wire

/* rtl/data_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module data_ram (
	input  logic               clk,
	input  logic               rst_n,
	input  mem_pkg::word_t     busaddr,
	input  logic               rd_req,
	input  logic               wr_req,
	input  mem_pkg::word_t     wr_data,
	input  mem_pkg::bus_size_t data_size,
	output mem_pkg::word_t     rd_data,
	output logic               rw_wait
);
	import mem_pkg::*;

	word_t                           mem [RAM_WORDS];
	logic [RAM_ADDR_W-1:0]           word_idx;
	logic [1:0]                      lane;
	logic                            req;
	logic [$bits(WAIT_CYCLES)-1:0]   wait_cnt;

	assign word_idx = busaddr[RAM_ADDR_W+1:2];
	assign lane     = busaddr[1:0];
	assign req      = rd_req || wr_req;

	// each request sees rw_wait for the first WAIT_CYCLES cycles.
	assign rw_wait = req && (wait_cnt < WAIT_CYCLES);
	assign rd_data = mem[word_idx];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			wait_cnt <= '0;
		else if (!req || !rw_wait)
			wait_cnt <= '0;
		else
			wait_cnt <= wait_cnt + 1'b1;
	end

	always_ff @(posedge clk) begin
		if (wr_req && !rw_wait) begin
			if (data_size == SIZE_BYTE)
				mem[word_idx][{lane, 3'b000} +: 8] <= wr_data[{lane, 3'b000} +: 8];
			else
				mem[word_idx] <= wr_data;
		end
	end

endmodule

`default_nettype wire

/* rtl/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              wr_en,
	input  mem_pkg::reg_num_t wr_num,
	input  mem_pkg::word_t    wr_data,
	input  mem_pkg::reg_num_t st_read,
	output mem_pkg::word_t    st_data
);
	import mem_pkg::*;

	word_t regs [16];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 16; i++)
				regs[i] <= '0;
		end else if (wr_en) begin
			regs[wr_num] <= wr_data;
		end
	end

	// read port for block stores.
	assign st_data = regs[st_read];

endmodule

`default_nettype wire

/* rtl/mem_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_stage (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                flush,
	input  logic                inbubble,
	input  mem_pkg::word_t      pc,
	input  mem_pkg::word_t      insn,
	input  mem_pkg::word_t      op0,
	input  mem_pkg::word_t      op1,
	input  mem_pkg::word_t      op2,
	input  logic                write_reg,
	input  mem_pkg::reg_num_t   write_num,
	input  mem_pkg::word_t      write_data,
	input  logic                rw_wait,
	input  mem_pkg::word_t      rd_data,
	input  mem_pkg::word_t      st_data,
	input  mem_pkg::reg_num_t   cur_reg,
	input  mem_pkg::word_t      list_offset,
	input  logic                list_last,
	output mem_pkg::word_t      busaddr,
	output logic                rd_req,
	output logic                wr_req,
	output mem_pkg::word_t      wr_data,
	output mem_pkg::bus_size_t  data_size,
	output mem_pkg::reg_num_t   st_read,
	output logic                list_load,
	output logic                list_step,
	output logic                outstall,
	output logic                outbubble,
	output mem_pkg::word_t      outpc,
	output mem_pkg::word_t      outinsn,
	output logic                out_write_reg,
	output mem_pkg::reg_num_t   out_write_num,
	output mem_pkg::word_t      out_write_data
);
	import mem_pkg::*;

	insn_class_t  cls;
	stage_state_t state, cur_state, next_state;
	logic         is_load, is_byte, up, pre, wb, base_wb_needed;
	word_t        indexed, xfer_addr, list_sel, beat_addr, list_base;
	word_t        rot_data, load_data, store_src, store_data;
	word_t        swp_data, next_swp;
	bus_size_t    xfer_size;
	logic         next_bubble, next_wr_reg;
	reg_num_t     next_wr_num;
	word_t        next_wr_data;

	// ----------------------------------------------------------------------
	// decode and address generation
	// ----------------------------------------------------------------------

	assign cls     = decode_class(insn);
	assign is_load = insn[20];
	assign wb      = insn[21];
	assign is_byte = insn[22];
	assign up      = insn[23];
	assign pre     = insn[24];

	// a post-indexed transfer always writes the base back.
	assign base_wb_needed = wb || !pre;

	assign indexed   = up ? op0 + op1 : op0 - op1;
	assign xfer_addr = (cls == CLS_SWP) ? op0 : (pre ? indexed : op0);
	assign xfer_size = is_byte ? SIZE_BYTE : SIZE_WORD;

	assign list_sel  = pre ? list_offset + 32'd4 : list_offset;
	assign beat_addr = up ? op0 + list_sel : op0 - list_sel;
	assign list_base = up ? op0 + list_offset : op0 - list_offset;

	// the first cycle of a block transfer is its setup cycle.
	assign cur_state = (cls == CLS_LDMSTM && state == ST_ACCESS) ? ST_LIST_SETUP : state;

	// rotate right so the addressed byte lands in lane 0.
	always_comb begin
		case (xfer_addr[1:0])
			2'd0: rot_data = rd_data;
			2'd1: rot_data = {rd_data[7:0], rd_data[31:8]};
			2'd2: rot_data = {rd_data[15:0], rd_data[31:16]};
			default: rot_data = {rd_data[23:0], rd_data[31:24]};
		endcase
	end

	assign load_data  = is_byte ? {24'b0, rot_data[7:0]} : rot_data;
	assign store_src  = (cls == CLS_SWP) ? op1 : op2;
	assign store_data = is_byte ? {4{store_src[7:0]}} : store_src;

	// ----------------------------------------------------------------------
	// control
	// ----------------------------------------------------------------------

	always_comb begin
		next_state   = state;
		busaddr      = '0;
		rd_req       = 1'b0;
		wr_req       = 1'b0;
		wr_data      = '0;
		data_size    = SIZE_WORD;
		st_read      = '0;
		list_load    = 1'b0;
		list_step    = 1'b0;
		outstall     = 1'b0;
		next_bubble  = inbubble;
		next_wr_reg  = write_reg;
		next_wr_num  = write_num;
		next_wr_data = write_data;
		next_swp     = swp_data;

		if (flush) begin
			next_bubble = 1'b1;
			next_wr_reg = 1'b0;
			next_state  = ST_ACCESS;
		end else if (!inbubble) begin
			case (cur_state)
				ST_ACCESS: begin
					case (cls)
						CLS_LDRSTR: begin
							busaddr      = xfer_addr;
							rd_req       = is_load;
							wr_req       = !is_load;
							data_size    = xfer_size;
							wr_data      = store_data;
							next_bubble  = rw_wait;
							next_wr_reg  = is_load;
							next_wr_num  = insn[15:12];
							next_wr_data = load_data;
							outstall     = rw_wait || base_wb_needed;
							if (!rw_wait && base_wb_needed)
								next_state = ST_BASE_WB;
						end
						CLS_SWP: begin
							busaddr     = xfer_addr;
							rd_req      = 1'b1;
							data_size   = xfer_size;
							next_bubble = 1'b1;
							next_wr_reg = 1'b0;
							outstall    = 1'b1;
							if (!rw_wait) begin
								next_swp   = load_data;
								next_state = ST_SWP_WRITE;
							end
						end
						default: begin
						end
					endcase
				end
				ST_SWP_WRITE: begin
					busaddr      = xfer_addr;
					wr_req       = 1'b1;
					data_size    = xfer_size;
					wr_data      = store_data;
					next_bubble  = rw_wait;
					next_wr_reg  = !rw_wait;
					next_wr_num  = insn[15:12];
					next_wr_data = swp_data;
					outstall     = rw_wait;
					if (!rw_wait)
						next_state = ST_ACCESS;
				end
				ST_BASE_WB: begin
					next_bubble  = 1'b0;
					next_wr_reg  = (cls == CLS_LDMSTM) ? wb : 1'b1;
					next_wr_num  = insn[19:16];
					next_wr_data = (cls == CLS_LDMSTM) ? list_base : indexed;
					next_state   = ST_ACCESS;
				end
				ST_LIST_SETUP: begin
					list_load   = 1'b1;
					outstall    = 1'b1;
					next_bubble = 1'b1;
					next_wr_reg = 1'b0;
					next_state  = ST_LIST_XFER;
				end
				ST_LIST_XFER: begin
					busaddr      = beat_addr;
					rd_req       = is_load;
					wr_req       = !is_load;
					st_read      = cur_reg;
					wr_data      = st_data;
					outstall     = 1'b1;
					next_bubble  = rw_wait;
					next_wr_reg  = is_load;
					next_wr_num  = cur_reg;
					next_wr_data = rd_data;
					if (!rw_wait) begin
						list_step = 1'b1;
						if (list_last)
							next_state = ST_BASE_WB;
					end
				end
				default: next_state = ST_ACCESS;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state         <= ST_ACCESS;
			outbubble     <= 1'b1;
			out_write_reg <= 1'b0;
		end else begin
			state         <= next_state;
			outbubble     <= next_bubble;
			out_write_reg <= next_wr_reg;
		end
	end

	always_ff @(posedge clk) begin
		outpc          <= pc;
		outinsn        <= insn;
		out_write_num  <= next_wr_num;
		out_write_data <= next_wr_data;
		swp_data       <= next_swp;
	end

	a_one_request: assert property (@(posedge clk) disable iff (!rst_n)
		!(rd_req && wr_req));

	// the previous stage may move on freely while it sends bubbles.
	a_no_stall_on_bubble: assert property (@(posedge clk) disable iff (!rst_n)
		inbubble |-> !outstall);

endmodule

`default_nettype wire

/* rtl/mem_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              flush,
	input  logic              inbubble,
	input  mem_pkg::word_t    pc,
	input  mem_pkg::word_t    insn,
	input  mem_pkg::word_t    op0,
	input  mem_pkg::word_t    op1,
	input  mem_pkg::word_t    op2,
	input  logic              write_reg,
	input  mem_pkg::reg_num_t write_num,
	input  mem_pkg::word_t    write_data,
	output logic              outstall,
	output logic              outbubble,
	output mem_pkg::word_t    outpc,
	output mem_pkg::word_t    outinsn,
	output logic              out_write_reg,
	output mem_pkg::reg_num_t out_write_num,
	output mem_pkg::word_t    out_write_data
);
	import mem_pkg::*;

	word_t     busaddr, wr_data, rd_data, st_data, list_offset;
	logic      rd_req, wr_req, rw_wait;
	bus_size_t data_size;
	reg_num_t  st_read, cur_reg;
	logic      list_load, list_step, list_last;

	mem_stage u_stage (
		.clk, .rst_n, .flush, .inbubble, .pc, .insn, .op0, .op1, .op2,
		.write_reg, .write_num, .write_data,
		.rw_wait, .rd_data, .st_data, .cur_reg, .list_offset, .list_last,
		.busaddr, .rd_req, .wr_req, .wr_data, .data_size, .st_read,
		.list_load, .list_step, .outstall, .outbubble, .outpc, .outinsn,
		.out_write_reg, .out_write_num, .out_write_data
	);

	// register list and direction come straight from the held instruction.
	ldm_sequencer u_seq (
		.clk, .rst_n, .list_load, .list_step,
		.reg_list   (op1[15:0]),
		.descending (!insn[23]),
		.cur_reg, .list_offset, .list_last
	);

	data_ram u_ram (
		.clk, .rst_n, .busaddr, .rd_req, .wr_req, .wr_data, .data_size,
		.rd_data, .rw_wait
	);

	reg_file u_regs (
		.clk, .rst_n,
		.wr_en   (out_write_reg && !outbubble),
		.wr_num  (out_write_num),
		.wr_data (out_write_data),
		.st_read, .st_data
	);

endmodule

`default_nettype wire

/* bench/clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module clock_gen (
	output logic clk,
	output logic rst_n
);
	localparam int HALF_PERIOD = 10;
	localparam int RESET_CYCLES = 10;

	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
	end

endmodule

`default_nettype wire

/* bench/tb_mem_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsystem;

	localparam int MAX_TESTS   = 32;
	localparam int MAX_EXP     = 64;
	localparam int STALL_LIMIT = 50;
	localparam int RESET_LIMIT = 100;

	logic        clk, rst_n;
	logic        flush, inbubble, write_reg;
	logic [31:0] pc, insn, op0, op1, op2, write_data;
	logic [3:0]  write_num;
	logic        outstall, outbubble, out_write_reg;
	logic [31:0] outpc, outinsn, out_write_data;
	logic [3:0]  out_write_num;

	// the test table is filled from the data file before the run starts.
	logic [127:0] t_name [MAX_TESTS];
	logic [31:0]  t_insn [MAX_TESTS];
	logic [31:0]  t_op0 [MAX_TESTS];
	logic [31:0]  t_op1 [MAX_TESTS];
	logic [31:0]  t_op2 [MAX_TESTS];
	logic [31:0]  t_wdata [MAX_TESTS];
	logic [3:0]   t_wnum [MAX_TESTS];
	logic         t_wreg [MAX_TESTS];
	logic         t_flush [MAX_TESTS];
	logic         t_bubble [MAX_TESTS];
	int           t_exp_first [MAX_TESTS];
	int           t_exp_count [MAX_TESTS];
	logic [3:0]   e_num [MAX_EXP];
	logic [31:0]  e_value [MAX_EXP];
	int           n_tests, n_exp;

	int           errors, failed_tests;
	logic         aborted;
	logic [3:0]   got_num [$];
	logic [31:0]  got_value [$];

	clock_gen u_clk (
		.clk,
		.rst_n
	);

	mem_subsystem uut (
		.clk, .rst_n, .flush, .inbubble, .pc, .insn, .op0, .op1, .op2,
		.write_reg, .write_num, .write_data,
		.outstall, .outbubble, .outpc, .outinsn,
		.out_write_reg, .out_write_num, .out_write_data
	);

	task automatic check_value(input logic [127:0] test_name, input string field,
			input logic [31:0] expected, input logic [31:0] actual);
		if (expected !== actual) begin
			$display("ERR %0s %0s: expected %08h, actual %08h", test_name, field,
				expected, actual);
			errors++;
		end
	endtask

	task automatic load_tests();
		int           fd;
		int           n;
		logic [127:0] tag;
		logic [127:0] name;
		logic [1023:0] rest;
		logic [31:0]  f_insn, f_op0, f_op1, f_op2, f_wreg, f_wnum, f_wdata;
		logic [31:0]  f_flush, f_bubble, f_num, f_value;
		n_tests = 0;
		n_exp = 0;
		fd = $fopen("bench/mem_input.txt", "r");
		if (fd == 0) begin
			$display("cannot open the data file bench/mem_input.txt");
			errors++;
		end else begin
			while (!$feof(fd)) begin
				tag = '0;
				n = $fscanf(fd, "%s", tag);
				if (n != 1)
					break;
				if (tag == "#") begin
					n = $fgets(rest, fd);
				end else if (tag == "T" && n_tests < MAX_TESTS) begin
					n = $fscanf(fd, "%s %h %h %h %h %h %h %h %h %h", name, f_insn, f_op0,
						f_op1, f_op2, f_wreg, f_wnum, f_wdata, f_flush, f_bubble);
					if (n != 10) begin
						$display("instruction line %0d in the data file is incomplete", n_tests);
						errors++;
					end
					t_name[n_tests]      = name;
					t_insn[n_tests]      = f_insn;
					t_op0[n_tests]       = f_op0;
					t_op1[n_tests]       = f_op1;
					t_op2[n_tests]       = f_op2;
					t_wreg[n_tests]      = f_wreg[0];
					t_wnum[n_tests]      = f_wnum[3:0];
					t_wdata[n_tests]     = f_wdata;
					t_flush[n_tests]     = f_flush[0];
					t_bubble[n_tests]    = f_bubble[0];
					t_exp_first[n_tests] = n_exp;
					t_exp_count[n_tests] = 0;
					n_tests++;
				end else if (tag == "E" && n_tests > 0 && n_exp < MAX_EXP) begin
					n = $fscanf(fd, "%h %h", f_num, f_value);
					if (n != 2) begin
						$display("expected line %0d in the data file is incomplete", n_exp);
						errors++;
					end
					e_num[n_exp]   = f_num[3:0];
					e_value[n_exp] = f_value;
					n_exp++;
					t_exp_count[n_tests - 1]++;
				end else begin
					$display("data file holds an unexpected line starting with %0s", tag);
					errors++;
				end
			end
			$fclose(fd);
			if (n_tests == 0) begin
				$display("the data file holds no tests");
				errors++;
			end
		end
	endtask

	task automatic collect_writeback();
		if (out_write_reg && !outbubble) begin
			got_num.push_back(out_write_num);
			got_value.push_back(out_write_data);
		end
	endtask

	task automatic run_test(input int idx);
		int          cycles;
		int          errors_before;
		int          n_cmp;
		int          base;
		logic        done;
		logic [31:0] test_pc;
		errors_before = errors;
		base = t_exp_first[idx];
		test_pc = 32'h1000 + 32'(idx * 4);
		@(posedge clk);
		pc         <= test_pc;
		insn       <= t_insn[idx];
		op0        <= t_op0[idx];
		op1        <= t_op1[idx];
		op2        <= t_op2[idx];
		write_reg  <= t_wreg[idx];
		write_num  <= t_wnum[idx];
		write_data <= t_wdata[idx];
		flush      <= t_flush[idx];
		inbubble   <= t_bubble[idx];
		got_num.delete();
		got_value.delete();
		cycles = 0;
		done = 1'b0;
		// outputs seen at the first falling edge still belong to the bubble before.
		while (!done && cycles < STALL_LIMIT) begin
			@(negedge clk);
			if (cycles > 0)
				collect_writeback();
			if (!outstall)
				done = 1'b1;
			else
				cycles++;
		end
		if (!done) begin
			$display("test %0s: timed out, outstall still high after %0d cycles",
				t_name[idx], STALL_LIMIT);
			errors++;
			failed_tests++;
			aborted = 1'b1;
		end else begin
			if ((t_flush[idx] || t_bubble[idx]) && cycles != 0) begin
				$display("test %0s: outstall went high during a flush or bubble", t_name[idx]);
				errors++;
			end
			@(posedge clk);
			inbubble  <= 1'b1;
			flush     <= 1'b0;
			write_reg <= 1'b0;
			@(negedge clk);
			collect_writeback();
			check_value(t_name[idx], "outpc", test_pc, outpc);
			check_value(t_name[idx], "outinsn", t_insn[idx], outinsn);
			if (t_flush[idx] || t_bubble[idx])
				check_value(t_name[idx], "outbubble", 32'd1, {31'd0, outbubble});
			if (got_num.size() != t_exp_count[idx]) begin
				$display("test %0s: expected %0d writebacks but saw %0d", t_name[idx],
					t_exp_count[idx], got_num.size());
				errors++;
			end
			n_cmp = (got_num.size() < t_exp_count[idx]) ? got_num.size() : t_exp_count[idx];
			for (int k = 0; k < n_cmp; k++) begin
				check_value(t_name[idx], "reg", {28'd0, e_num[base + k]}, {28'd0, got_num[k]});
				check_value(t_name[idx], "value", e_value[base + k], got_value[k]);
			end
			if (errors == errors_before) begin
				$display("test %0s: passed", t_name[idx]);
			end else begin
				$display("test %0s: failed with %0d errors", t_name[idx], errors - errors_before);
				failed_tests++;
			end
		end
	endtask

	// ----------------------------------------------------------------------
	// main sequence
	// ----------------------------------------------------------------------

	initial begin
		int waited;
		flush        = 1'b0;
		inbubble     = 1'b1;
		write_reg    = 1'b0;
		write_num    = '0;
		write_data   = '0;
		pc           = '0;
		insn         = '0;
		op0          = '0;
		op1          = '0;
		op2          = '0;
		errors       = 0;
		failed_tests = 0;
		aborted      = 1'b0;
		load_tests();
		waited = 0;
		while (!rst_n && waited < RESET_LIMIT) begin
			@(posedge clk);
			waited++;
		end
		if (!rst_n) begin
			$display("reset was never released");
			errors++;
			aborted = 1'b1;
		end
		for (int i = 0; i < n_tests && !aborted; i++)
			run_test(i);
		$display("tests %0d, failed %0d, errors %0d", n_tests, failed_tests, errors);
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* bench/mem_input.txt */
# T name insn op0 op1 op2 write_reg write_num write_data flush inbubble (hex after name)
# E reg value, one line for each expected writeback, in the order they appear
T pass_r1 E1A00000 0 0 0 1 1 11223344 0 0
E 1 11223344
T pass_r2 E1A00000 0 0 0 1 2 A5A5F00F 0 0
E 2 A5A5F00F
T pass_r3 E1A00000 0 0 0 1 3 00000003 0 0
E 3 00000003
T pass_r4 E1A00000 0 0 0 1 4 CAFEBABE 0 0
E 4 CAFEBABE
T str_word E5801000 00000100 0 11223344 0 0 0 0 0
T ldr_word E5905000 00000100 0 0 0 0 0 0 0
E 5 11223344
T str_word2 E5801000 00000104 0 55667788 0 0 0 0 0
T strb_lane2 E5C06000 00000104 2 000000AB 0 0 0 0 0
T ldrb_lane2 E5D07000 00000104 2 0 0 0 0 0 0
E 7 000000AB
T ldr_rot8 E5908000 00000104 1 0 0 0 0 0 0
E 8 8855AB77
T ldr_pre_wb E53A9000 00000108 4 0 0 0 0 0 0
E 9 55AB7788
E A 00000104
T ldr_post E49CB000 00000100 8 0 0 0 0 0 0
E B 11223344
E C 00000108
T stmia_r1_r4 E8A0001E 00000200 0000001E 0 0 0 0 0 0
E 0 00000210
T ldmda_r5_r8 E83D01E0 0000020C 000001E0 0 0 0 0 0 0
E 8 CAFEBABE
E 7 00000003
E 6 A5A5F00F
E 5 11223344
E D 000001FC
T swp_word E100E093 00000100 DEADBEEF 0 0 0 0 0 0
E E 11223344
T ldr_after_swp E5905000 00000100 0 0 0 0 0 0 0
E 5 DEADBEEF
T flush_ldr E5905000 00000100 0 0 0 0 0 1 0
T bubble_pass E1A00000 0 0 0 1 1 FFFFFFFF 0 1

/* build.f */
rtl/mem_pkg.sv
rtl/ldm_sequencer.sv
rtl/data_ram.sv
rtl/reg_file.sv
rtl/mem_stage.sv
rtl/mem_subsystem.sv
bench/clock_gen.sv
bench/tb_mem_subsystem.sv

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_mem_subsystem \
	-f build.f -o tb_sim || { echo "verilator build failed"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
cat sim.log
grep -q "FAIL: see errors above" sim.log && { echo "simulation reported errors"; exit 1; }
grep -q "PASS: all tests" sim.log || { echo "simulation did not finish cleanly"; exit 1; }
exit 0
